//--- spi_loader_pkg.sv
package spi_loader_pkg;

    localparam logic [7:0]  read_opcode = 8'h03;        // plain read
    localparam int          cmd_bits    = 32;           // opcode + 24 bit address
    localparam logic [11:0] boot_page   = 12'h805;      // bootloader region
    localparam logic [11:0] boot_bits   = 12'd2656;
    localparam logic [11:0] map_bits    = 12'd1200;     // bad loop map length
    localparam logic [11:0] head_loops  = 12'd6;        // good loops in page head
    localparam logic [11:0] page_bits   = 12'd1030;     // good data loops per page

    localparam int map_aw  = 12;
    localparam int out_aw  = 15;
    localparam int fifo_aw = 13;

    localparam logic [out_aw-1:0] out_page_base = 15'd14336;   // page image start

    typedef logic [11:0] page_t;
    typedef logic [2:0]  img_t;

    // bit 1 marks an active access, bit 0 picks page (1) or boot (0)
    typedef logic [2:0]  acc_t;

    localparam acc_t acc_boot_send = 3'b110;
    localparam acc_t acc_user_send = 3'b111;

endpackage

//--- spi_flash_master.sv
`timescale 1ns/1ns

module spi_flash_master
(
    input  logic                                MCLK,
    input  logic                                arst_n,
    input  logic                                cmd_start,
    input  logic [spi_loader_pkg::cmd_bits-1:0] cmd_word,
    input  logic                                bit_req,
    input  logic                                cs_release,
    output logic                                cmd_ready,
    output logic                                bit_valid,
    output logic                                bit_data,
    output logic                                flash_cs_n,
    output logic                                sclk,
    output logic                                mosi,
    output logic                                mosi_oe,
    input  logic                                miso
);

    import spi_loader_pkg::*;

    typedef enum logic [1:0] {
        M_IDLE,     // cs high, waiting for a command
        M_CMD,      // read command shifting out
        M_OPEN,     // cs low, read stream open
        M_BIT       // one data bit in flight
    } mstate_t;

    mstate_t                     mstate;
    logic [cmd_bits-1:0]         cmd_sr;
    logic [$clog2(cmd_bits)-1:0] bit_cnt;

    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mstate     <= M_IDLE;
            bit_cnt    <= '0;
            cmd_ready  <= 1'b1;
            bit_valid  <= 1'b0;
            flash_cs_n <= 1'b1;
            sclk       <= 1'b1;
            mosi_oe    <= 1'b0;
        end
        else
        begin
            bit_valid <= 1'b0;
            if (cs_release)
            begin
                mstate     <= M_IDLE;
                cmd_ready  <= 1'b1;
                flash_cs_n <= 1'b1;
                sclk       <= 1'b1;
                mosi_oe    <= 1'b0;
            end
            else
            begin
                case (mstate)
                    M_IDLE:
                        if (cmd_start)
                        begin
                            mstate     <= M_CMD;
                            bit_cnt    <= '0;
                            cmd_ready  <= 1'b0;
                            flash_cs_n <= 1'b0;
                            sclk       <= 1'b0;     // first bit goes out with sclk low
                            mosi_oe    <= 1'b1;
                        end
                    M_CMD:
                        if (!sclk)
                        begin
                            sclk <= 1'b1;           // flash latches mosi here
                            if (bit_cnt == $bits(bit_cnt)'(cmd_bits - 1))
                            begin
                                mstate    <= M_OPEN;
                                cmd_ready <= 1'b1;
                            end
                        end
                        else
                        begin
                            sclk    <= 1'b0;
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    M_OPEN:
                    begin
                        mosi_oe <= 1'b0;            // io0 back to the flash
                        if (bit_req)
                        begin
                            mstate    <= M_BIT;
                            cmd_ready <= 1'b0;
                            sclk      <= 1'b0;      // flash shifts next bit out
                        end
                    end
                    default:
                    begin
                        mstate    <= M_OPEN;
                        cmd_ready <= 1'b1;
                        bit_valid <= 1'b1;
                        sclk      <= 1'b1;
                    end
                endcase
            end
        end
    end

    // command shifter, MSB first, and the sampled read bit
    always_ff @(posedge MCLK)
    begin
        if (mstate == M_IDLE && cmd_start)
        begin
            mosi   <= cmd_word[cmd_bits-1];
            cmd_sr <= cmd_word << 1;
        end
        else if (mstate == M_CMD && sclk)
        begin
            mosi   <= cmd_sr[cmd_bits-1];
            cmd_sr <= cmd_sr << 1;
        end
        if (mstate == M_BIT)
            bit_data <= miso;               // sampled as sclk rises
    end

endmodule

//--- bad_loop_map.sv
`timescale 1ns/1ns

module bad_loop_map
(
    input  logic                              MCLK,
    input  logic                              map_we,
    input  logic                              map_re,
    input  logic [spi_loader_pkg::map_aw-1:0] map_addr,
    input  logic                              map_wdata,
    output logic                              map_rdata
);

    import spi_loader_pkg::*;

    logic              table_mem [0:2**map_aw-1];
    logic [map_aw-1:0] wr_addr;

    // the flash stores each group of 16 loops in reverse order
    assign wr_addr = {map_addr[map_aw-1:4], ~map_addr[3:0]};

    always_ff @(posedge MCLK)
    begin
        if (map_we)
            table_mem[wr_addr] <= map_wdata;
    end

    always_ff @(posedge MCLK)
    begin
        if (map_re)
            map_rdata <= table_mem[map_addr];   // 1 = good loop
    end

endmodule

//--- load_sequencer.sv
`timescale 1ns/1ns

module load_sequencer
(
    input  logic                                MCLK,
    input  logic                                arst_n,
    input  spi_loader_pkg::img_t                img,
    input  spi_loader_pkg::page_t               page,
    input  spi_loader_pkg::acc_t                acc_type,
    input  logic                                cmd_ready,
    input  logic                                bit_valid,
    input  logic                                bit_data,
    output logic                                cmd_start,
    output logic [spi_loader_pkg::cmd_bits-1:0] cmd_word,
    output logic                                bit_req,
    output logic                                cs_release,
    output logic                                map_we,
    output logic                                map_re,
    output logic [spi_loader_pkg::map_aw-1:0]   map_addr,
    output logic                                map_wdata,
    input  logic                                map_rdata,
    output logic                                out_we_n,
    output logic [spi_loader_pkg::out_aw-1:0]   out_addr,
    output logic                                out_data,
    output logic                                fifo_we_n,
    output logic [spi_loader_pkg::fifo_aw-1:0]  fifo_addr,
    output logic                                fifo_data,
    output logic                                send_boot_n,
    output logic                                send_user_n
);

    import spi_loader_pkg::*;

    typedef enum logic [4:0] {
        S_IDLE, S_PREP, S_CMD, S_CMD_WAIT,
        S_B_REQ, S_B_WAIT, S_B_WR,              // bootloader and map copy
        S_H_RD, S_H_CHK, S_H_WR,                // page head expansion
        S_D_RD, S_D_CHK, S_D_REQ, S_D_WAIT, S_D_WR,
        S_REL, S_DONE
    } state_t;

    state_t      state;
    logic [11:0] gcnt;          // bits or good loops done in this phase
    logic        map_ph;        // boot branch is copying the map
    logic        good;          // current loop is good
    logic        wr_bit;

    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= S_IDLE;
            gcnt      <= '0;
            map_ph    <= 1'b0;
            out_addr  <= '0;
            fifo_addr <= '0;
            map_addr  <= '0;
        end
        else if (!acc_type[1])
            state <= S_IDLE;                    // host ended the access
        else
        begin
            case (state)
                S_IDLE:
                begin
                    state     <= S_PREP;
                    gcnt      <= '0;
                    map_ph    <= 1'b0;
                    fifo_addr <= '0;
                    map_addr  <= '0;
                end
                S_PREP: state <= S_CMD;
                S_CMD:  state <= S_CMD_WAIT;
                S_CMD_WAIT:
                    if (cmd_ready)
                    begin
                        if (acc_type[0])
                        begin
                            out_addr <= out_page_base;
                            state    <= S_H_RD;
                        end
                        else
                        begin
                            out_addr <= '0;
                            state    <= S_B_REQ;
                        end
                    end
                S_B_REQ:  state <= S_B_WAIT;
                S_B_WAIT:
                    if (bit_valid)
                        state <= S_B_WR;
                S_B_WR:
                begin
                    out_addr  <= out_addr + 1'b1;
                    fifo_addr <= fifo_addr + 1'b1;
                    gcnt      <= gcnt + 1'b1;
                    state     <= S_B_REQ;
                    if (map_ph)
                    begin
                        map_addr <= map_addr + 1'b1;
                        if (gcnt == map_bits - 1'b1)
                            state <= S_REL;
                    end
                    else if (gcnt == boot_bits - 1'b1)
                    begin
                        map_ph <= 1'b1;         // map follows right after the bootloader
                        gcnt   <= '0;
                    end
                end
                S_H_RD: state <= S_H_CHK;
                S_H_CHK:
                begin
                    map_addr <= map_addr + 1'b1;
                    state    <= S_H_WR;
                end
                S_H_WR:
                begin
                    out_addr <= out_addr + 1'b1;
                    state    <= S_H_RD;
                    if (good)
                    begin
                        gcnt <= gcnt + 1'b1;
                        if (gcnt == head_loops - 1'b1)
                        begin
                            gcnt  <= '0;
                            state <= S_D_RD;
                        end
                    end
                end
                S_D_RD: state <= S_D_CHK;
                S_D_CHK:
                begin
                    map_addr <= map_addr + 1'b1;
                    state    <= map_rdata ? S_D_REQ : S_D_WR;    // bad loop skips flash
                end
                S_D_REQ:  state <= S_D_WAIT;
                S_D_WAIT:
                    if (bit_valid)
                        state <= S_D_WR;
                S_D_WR:
                begin
                    out_addr <= out_addr + 1'b1;
                    state    <= S_D_RD;
                    if (good)
                    begin
                        fifo_addr <= fifo_addr + 1'b1;
                        gcnt      <= gcnt + 1'b1;
                        if (gcnt == page_bits - 1'b1)
                            state <= S_REL;
                    end
                end
                S_REL: state <= S_DONE;
                default: state <= S_DONE;       // wait for the host to drop the access
            endcase
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (state == S_PREP)
            cmd_word <= {read_opcode, 2'b00, img, acc_type[0] ? page : boot_page, 7'd0};
        if (state == S_H_CHK || state == S_D_CHK)
        begin
            good   <= map_rdata;
            wr_bit <= (state == S_H_CHK) && map_rdata;  // head writes 1 per good loop
        end
        else if (bit_valid)
            wr_bit <= bit_data;
    end

    assign cmd_start  = (state == S_CMD);
    assign bit_req    = (state == S_B_REQ) || (state == S_D_REQ);
    assign map_re     = (state == S_H_RD) || (state == S_D_RD);
    assign map_we     = (state == S_B_WR) && map_ph;
    assign cs_release = (state == S_REL) || ((state != S_IDLE) && !acc_type[1]);

    assign out_we_n  = !((state == S_B_WR) || (state == S_H_WR) || (state == S_D_WR));
    assign fifo_we_n = !((state == S_B_WR) || ((state == S_D_WR) && good));

    // one write bit feeds every sink
    assign out_data  = wr_bit;
    assign fifo_data = wr_bit;
    assign map_wdata = wr_bit;

    assign send_boot_n = !((state == S_DONE) && (acc_type == acc_boot_send));
    assign send_user_n = !((state == S_DONE) && (acc_type == acc_user_send));

endmodule

//--- spi_loader_top.sv
`timescale 1ns/1ns

module spi_loader_top
(
    input  logic                               MCLK,
    input  logic                               arst_n,
    input  spi_loader_pkg::img_t               img,
    input  spi_loader_pkg::page_t              page,
    input  spi_loader_pkg::acc_t               acc_type,
    output logic                               out_we_n,
    output logic [spi_loader_pkg::out_aw-1:0]  out_addr,
    output logic                               out_data,
    output logic                               fifo_we_n,
    output logic [spi_loader_pkg::fifo_aw-1:0] fifo_addr,
    output logic                               fifo_data,
    output logic                               send_boot_n,
    output logic                               send_user_n,
    output logic                               flash_cs_n,
    output logic                               sclk,
    inout  wire                                io0,
    input  logic                               io1
);

    import spi_loader_pkg::*;

    logic                cmd_start;
    logic [cmd_bits-1:0] cmd_word;
    logic                cmd_ready;
    logic                bit_req;
    logic                bit_valid;
    logic                bit_data;
    logic                cs_release;
    logic                mosi;
    logic                mosi_oe;
    logic                map_we;
    logic                map_re;
    logic [map_aw-1:0]   map_addr;
    logic                map_wdata;
    logic                map_rdata;

    assign io0 = mosi_oe ? mosi : 1'bz;     // io0 only driven during the command

    spi_flash_master u_flash
    (
        .MCLK       (MCLK),
        .arst_n     (arst_n),
        .cmd_start  (cmd_start),
        .cmd_word   (cmd_word),
        .bit_req    (bit_req),
        .cs_release (cs_release),
        .cmd_ready  (cmd_ready),
        .bit_valid  (bit_valid),
        .bit_data   (bit_data),
        .flash_cs_n (flash_cs_n),
        .sclk       (sclk),
        .mosi       (mosi),
        .mosi_oe    (mosi_oe),
        .miso       (io1)
    );

    bad_loop_map u_map
    (
        .MCLK      (MCLK),
        .map_we    (map_we),
        .map_re    (map_re),
        .map_addr  (map_addr),
        .map_wdata (map_wdata),
        .map_rdata (map_rdata)
    );

    load_sequencer u_seq
    (
        .MCLK        (MCLK),
        .arst_n      (arst_n),
        .img         (img),
        .page        (page),
        .acc_type    (acc_type),
        .cmd_ready   (cmd_ready),
        .bit_valid   (bit_valid),
        .bit_data    (bit_data),
        .cmd_start   (cmd_start),
        .cmd_word    (cmd_word),
        .bit_req     (bit_req),
        .cs_release  (cs_release),
        .map_we      (map_we),
        .map_re      (map_re),
        .map_addr    (map_addr),
        .map_wdata   (map_wdata),
        .map_rdata   (map_rdata),
        .out_we_n    (out_we_n),
        .out_addr    (out_addr),
        .out_data    (out_data),
        .fifo_we_n   (fifo_we_n),
        .fifo_addr   (fifo_addr),
        .fifo_data   (fifo_data),
        .send_boot_n (send_boot_n),
        .send_user_n (send_user_n)
    );

endmodule

//--- flash_model.sv
`timescale 1ns/1ns

module flash_model
(
    input  logic        flash_cs_n,
    input  logic        sclk,
    input  wire         io0,
    output logic        io1,
    output logic [31:0] cmd_seen,
    output int          cmd_len,
    output int          served
);

    import spi_loader_pkg::*;

    logic boot_mem [0:boot_bits-1];
    logic map_mem  [0:map_bits-1];     // 1 = good loop
    int   cmd_cnt;
    int   rd_idx;

    task automatic fill_streams();
        int bad;
        bad = 0;
        for (int i = 0; i < boot_bits; i++)
            boot_mem[i] = 1'($urandom);
        for (int i = 0; i < map_bits; i++)
        begin
            map_mem[i] = 1'b1;
            if (($urandom % 16) == 0 && bad < 150)    // about one bad loop in 16
            begin
                map_mem[i] = 1'b0;
                bad++;
            end
        end
    endtask

    // page data depends on the read address and the bit index only
    function automatic logic page_bit(input logic [23:0] addr, input int idx);
        logic [31:0] x;
        x = ({8'h00, addr} * 32'h9e37_79b1) ^ (idx * 32'h85eb_ca6b);
        x = x ^ (x >> 15);
        x = x * 32'h2c1b_3c6d;
        x = x ^ (x >> 13);
        return x[5];
    endfunction

    function automatic logic stream_bit(input int idx);
        if (cmd_seen[18:7] != boot_page)
            return page_bit(cmd_seen[23:0], idx);
        if (idx < boot_bits)
            return boot_mem[idx];
        if (idx < boot_bits + map_bits)
            return map_mem[idx - boot_bits];    // map follows the bootloader
        return 1'b0;
    endfunction

    initial
    begin
        cmd_cnt  = 0;
        rd_idx   = 0;
        cmd_len  = 0;
        served   = 0;
        cmd_seen = '0;
        io1      = 1'b0;
    end

    // end of a transfer, keep its lengths for the checks
    always @(posedge flash_cs_n)
    begin
        cmd_len = cmd_cnt;
        served  = rd_idx;
        cmd_cnt = 0;
        rd_idx  = 0;
    end

    always @(posedge sclk)
    begin
        if (!flash_cs_n && cmd_cnt < cmd_bits)
        begin
            cmd_seen = {cmd_seen[30:0], io0};
            cmd_cnt++;
        end
    end

    always @(negedge sclk)
    begin
        if (!flash_cs_n && cmd_cnt == cmd_bits)
        begin
            io1 <= stream_bit(rd_idx);      // next bit out on the falling edge
            rd_idx++;
        end
    end

endmodule

//--- tb_spi_loader.sv
`timescale 1ns/1ns

module tb_spi_loader;

    import spi_loader_pkg::*;

    localparam int          clk_period  = 40;
    localparam int          n_pages     = 4;
    localparam logic [31:0] seed        = 32'h75d0_d5ee;
    localparam int          watchdog_ns = (n_pages + 1) * 6 * 4000 * clk_period;

    logic               MCLK;
    logic               arst_n;
    img_t               img;
    page_t              page;
    acc_t               acc_type;
    logic               out_we_n;
    logic [out_aw-1:0]  out_addr;
    logic               out_data;
    logic               fifo_we_n;
    logic [fifo_aw-1:0] fifo_addr;
    logic               fifo_data;
    logic               send_boot_n;
    logic               send_user_n;
    logic               flash_cs_n;
    logic               sclk;
    wire                io0;
    logic               io1;
    logic [31:0]        cmd_seen;
    int                 cmd_len;
    int                 served;

    logic out_mem  [0:2**out_aw-1];
    logic fifo_mem [0:2**fifo_aw-1];
    int   out_cnt;
    int   fifo_cnt;
    logic exp_out  [$];
    logic exp_fifo [$];

    spi_loader_top u_dut
    (
        .MCLK        (MCLK),
        .arst_n      (arst_n),
        .img         (img),
        .page        (page),
        .acc_type    (acc_type),
        .out_we_n    (out_we_n),
        .out_addr    (out_addr),
        .out_data    (out_data),
        .fifo_we_n   (fifo_we_n),
        .fifo_addr   (fifo_addr),
        .fifo_data   (fifo_data),
        .send_boot_n (send_boot_n),
        .send_user_n (send_user_n),
        .flash_cs_n  (flash_cs_n),
        .sclk        (sclk),
        .io0         (io0),
        .io1         (io1)
    );

    flash_model u_flash_model
    (
        .flash_cs_n (flash_cs_n),
        .sclk       (sclk),
        .io0        (io0),
        .io1        (io1),
        .cmd_seen   (cmd_seen),
        .cmd_len    (cmd_len),
        .served     (served)
    );

    initial
    begin
        MCLK = 1'b0;
        forever #(clk_period / 2) MCLK = ~MCLK;
    end

    // buffer writes, sampled mid-cycle
    always @(negedge MCLK)
    begin
        if (!out_we_n)
        begin
            out_mem[out_addr] = out_data;
            out_cnt++;
        end
        if (!fifo_we_n)
        begin
            fifo_mem[fifo_addr] = fifo_data;
            fifo_cnt++;
        end
    end

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            $display("Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic check_idle(input string where);
        check_equal(flash_cs_n, 1'b1, {"flash_cs_n ", where});
        check_equal(sclk, 1'b1, {"sclk ", where});
        check_equal(out_we_n, 1'b1, {"out_we_n ", where});
        check_equal(fifo_we_n, 1'b1, {"fifo_we_n ", where});
        check_equal(send_boot_n, 1'b1, {"send_boot_n ", where});
        check_equal(send_user_n, 1'b1, {"send_user_n ", where});
    endtask

    // each group of 16 loops sits in the table in reverse order
    function automatic logic table_good(input int loop);
        int group;
        int pos;
        group = loop / 16;
        pos   = loop % 16;
        return u_flash_model.map_mem[group * 16 + 15 - pos];
    endfunction

    function automatic page_t random_page();
        page_t pg;
        pg = 12'($urandom);
        while (pg == boot_page)
            pg = 12'($urandom);     // boot region is not a page
        return pg;
    endfunction

    task automatic build_expected(input logic is_page, input page_t pg);
        logic [23:0] addr;
        int          loop;
        int          good_cnt;
        logic        g;
        logic        b;
        addr = {2'b00, img, pg, 7'd0};
        exp_out.delete();
        exp_fifo.delete();
        if (!is_page)
        begin
            for (int i = 0; i < boot_bits; i++)
            begin
                exp_out.push_back(u_flash_model.boot_mem[i]);
                exp_fifo.push_back(u_flash_model.boot_mem[i]);
            end
            for (int i = 0; i < map_bits; i++)
            begin
                exp_out.push_back(u_flash_model.map_mem[i]);
                exp_fifo.push_back(u_flash_model.map_mem[i]);
            end
        end
        else
        begin
            loop     = 0;
            good_cnt = 0;
            while (good_cnt < head_loops && loop < map_bits)
            begin
                g = table_good(loop);
                loop++;
                exp_out.push_back(g);   // head marks good loops with 1
                if (g)
                    good_cnt++;
            end
            good_cnt = 0;
            while (good_cnt < page_bits && loop < map_bits)
            begin
                g = table_good(loop);
                loop++;
                if (g)
                begin
                    b = u_flash_model.page_bit(addr, good_cnt);
                    exp_out.push_back(b);
                    exp_fifo.push_back(b);
                    good_cnt++;
                end
                else
                    exp_out.push_back(1'b0);
            end
        end
    endtask

    task automatic run_access(input logic is_page, input page_t pg);
        logic [31:0]       exp_cmd;
        logic [out_aw-1:0] base;
        int                exp_bits;
        exp_cmd = {read_opcode, 2'b00, img, is_page ? pg : boot_page, 7'd0};
        base    = is_page ? out_page_base : '0;
        build_expected(is_page, pg);
        exp_bits = is_page ? exp_fifo.size() : exp_out.size();
        foreach (out_mem[i])
            out_mem[i] = 1'bx;
        foreach (fifo_mem[i])
            fifo_mem[i] = 1'bx;
        out_cnt  = 0;
        fifo_cnt = 0;
        @(posedge MCLK);
        #5;
        page     = pg;
        acc_type = {1'b0, 1'b1, is_page};   // active, no send code yet
        repeat (2) @(posedge MCLK);
        @(negedge MCLK);
        check_equal(flash_cs_n, 1'b1, "flash_cs_n before cmd_start");
        @(negedge MCLK);
        check_equal(flash_cs_n, 1'b0, "flash_cs_n after cmd_start");
        while (out_cnt < exp_out.size())
            @(posedge MCLK);
        repeat (4) @(negedge MCLK);
        check_equal(send_boot_n, 1'b1, "send_boot_n without send code");
        check_equal(send_user_n, 1'b1, "send_user_n without send code");
        @(posedge MCLK);
        #5;
        acc_type[2] = 1'b1;
        while (send_boot_n && send_user_n)
            @(negedge MCLK);
        check_equal(send_boot_n, is_page, "send_boot_n");
        check_equal(send_user_n, !is_page, "send_user_n");
        check_equal(cmd_seen, exp_cmd, "read command on io0");
        check_equal(cmd_len, cmd_bits, "command length");
        check_equal(served, exp_bits, "flash bits read");
        check_equal(out_cnt, exp_out.size(), "out buffer write count");
        check_equal(fifo_cnt, exp_fifo.size(), "fifo buffer write count");
        foreach (exp_out[i])
            check_equal(out_mem[base + i], exp_out[i], $sformatf("out buffer at %0d", base + i));
        foreach (exp_fifo[i])
            check_equal(fifo_mem[i], exp_fifo[i], $sformatf("fifo buffer at %0d", i));
        @(posedge MCLK);
        #5;
        acc_type = '0;
        repeat (2) @(posedge MCLK);
        @(negedge MCLK);
        check_idle("after the access");
    endtask

    initial
    begin
        arst_n   = 1'b0;
        page     = '0;
        acc_type = '0;
        out_cnt  = 0;
        fifo_cnt = 0;
        void'($urandom(seed));
        u_flash_model.fill_streams();
        img = 3'($urandom);
        repeat (3) @(posedge MCLK);
        #5;
        arst_n = 1'b1;
        @(negedge MCLK);
        check_idle("after reset");
        check_equal(io0 === 1'bz, 1'b1, "io0 released after reset");
        run_access(1'b0, random_page());    // page input must not reach the boot command
        for (int n = 0; n < n_pages; n++)
            run_access(1'b1, random_page());
        $display("Everything OK");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the run did not finish within %0d ns", watchdog_ns);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- spi_loader_top.f
spi_loader_pkg.sv
spi_flash_master.sv
bad_loop_map.sv
load_sequencer.sv
spi_loader_top.sv
flash_model.sv
tb_spi_loader.sv
